// ==== verilog/apb_sys_pkg.sv ====
package apb_sys_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// address map, 8 KB per slot
	localparam int SLOT_LSB  = 13;
	localparam int NUM_SLOTS = 8;

	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;
	typedef logic [NUM_SLOTS-1:0]         slot_sel_t;

	localparam slot_idx_t SLOT_SRAM = 3'd0;
	localparam slot_idx_t SLOT_HPET = 3'd2;
	localparam slot_idx_t SLOT_CONF = 3'd3;

	// hpet registers
	localparam logic [3:0] HPET_CTRL   = 4'h0; // [0] count en, [1] int en
	localparam logic [3:0] HPET_COUNT  = 4'h4;
	localparam logic [3:0] HPET_CMP    = 4'h8;
	localparam logic [3:0] HPET_STATUS = 4'hC; // [0] sticky match, w1c

	// confreg registers
	localparam logic [3:0] CONF_INT_EN   = 4'h0;
	localparam logic [3:0] CONF_INT_PEND = 4'h4; // read only

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		addr_t             paddr;
		word_t             pwdata;
		logic [STRB_W-1:0] pstrb;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
	} apb_rsp_t;

endpackage

// ==== verilog/apb_slot_decode.sv ====
`timescale 1ns/1ps
module apb_slot_decode (
	input  apb_sys_pkg::apb_req_t  apb_req_i,
	input  apb_sys_pkg::word_t     sram_rdata_i,
	input  apb_sys_pkg::word_t     hpet_rdata_i,
	input  apb_sys_pkg::word_t     conf_rdata_i,
	output apb_sys_pkg::slot_sel_t sel_o,
	output apb_sys_pkg::apb_rsp_t  apb_rsp_o
);

	apb_sys_pkg::slot_idx_t slot;
	apb_sys_pkg::word_t     rdata;

	assign slot = apb_req_i.paddr[apb_sys_pkg::SLOT_LSB +: $bits(apb_sys_pkg::slot_idx_t)];

	// one-hot select, only while a transfer is on the bus
	always_comb begin
		for (int i = 0; i < apb_sys_pkg::NUM_SLOTS; i++) begin
			sel_o[i] = apb_req_i.psel && (slot == i);
		end
	end

	always_comb begin
		case (slot)
			apb_sys_pkg::SLOT_SRAM: begin
				rdata = sram_rdata_i;
			end
			apb_sys_pkg::SLOT_HPET: begin
				rdata = hpet_rdata_i;
			end
			apb_sys_pkg::SLOT_CONF: begin
				rdata = conf_rdata_i;
			end
			default: begin
				rdata = '0; // unmapped slot reads zero
			end
		endcase
	end

	assign apb_rsp_o.prdata = rdata;
	assign apb_rsp_o.pready = apb_req_i.psel & apb_req_i.penable; // zero wait states

endmodule

// ==== verilog/data_sram.sv ====
`timescale 1ns/1ps
module data_sram #(
	parameter int RAM_WORDS = 2048
) (
	input  logic                  clock,
	input  logic                  sel_i,
	input  apb_sys_pkg::apb_req_t apb_req_i,
	output apb_sys_pkg::word_t    rdata_o
);

	localparam int AW = $clog2(RAM_WORDS);

	apb_sys_pkg::word_t mem [RAM_WORDS];
	logic [AW-1:0]      addr_q;
	logic               setup;
	logic               wr_acc;

	assign setup  = sel_i & ~apb_req_i.penable;
	assign wr_acc = sel_i & apb_req_i.penable & apb_req_i.pwrite;

	// word address taken at the end of the setup cycle
	always_ff @(posedge clock) begin
		if (setup) begin
			addr_q <= apb_req_i.paddr[2 +: AW];
		end
	end

	always_ff @(posedge clock) begin
		if (wr_acc) begin
			for (int i = 0; i < apb_sys_pkg::STRB_W; i++) begin
				if (apb_req_i.pstrb[i]) begin
					mem[addr_q][i*8 +: 8] <= apb_req_i.pwdata[i*8 +: 8];
				end
			end
		end
	end

	// registered address, so this maps to block ram
	assign rdata_o = mem[addr_q];

endmodule

// ==== verilog/hpet_timer.sv ====
`timescale 1ns/1ps
module hpet_timer (
	input  logic                  clock,
	input  logic                  rst_n_i,
	input  logic                  sel_i,
	input  apb_sys_pkg::apb_req_t apb_req_i,
	output apb_sys_pkg::word_t    rdata_o,
	output logic                  timer_int_o
);

	logic [1:0]         ctrl_q;
	apb_sys_pkg::word_t count_q;
	apb_sys_pkg::word_t cmp_q;
	logic               status_q;
	logic [3:0]         off;
	logic               wr;
	logic               match;

	assign off   = apb_req_i.paddr[3:0];
	assign wr    = sel_i & apb_req_i.penable & apb_req_i.pwrite;
	assign match = ctrl_q[0] & (count_q == cmp_q);

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_q   <= '0;
			count_q  <= '0;
			cmp_q    <= '0;
			status_q <= 1'b0;
		end else begin
			if (wr && off == apb_sys_pkg::HPET_CTRL) begin
				ctrl_q <= apb_req_i.pwdata[1:0];
			end
			if (wr && off == apb_sys_pkg::HPET_CMP) begin
				cmp_q <= apb_req_i.pwdata;
			end
			// sw load beats the increment
			if (wr && off == apb_sys_pkg::HPET_COUNT) begin
				count_q <= apb_req_i.pwdata;
			end else if (ctrl_q[0]) begin
				count_q <= count_q + 1'b1; // wraps
			end
			if (match) begin
				status_q <= 1'b1;
			end else if (wr && off == apb_sys_pkg::HPET_STATUS && apb_req_i.pwdata[0]) begin
				status_q <= 1'b0;
			end
		end
	end

	always_comb begin
		case (off)
			apb_sys_pkg::HPET_CTRL:   rdata_o = apb_sys_pkg::word_t'(ctrl_q);
			apb_sys_pkg::HPET_COUNT:  rdata_o = count_q;
			apb_sys_pkg::HPET_CMP:    rdata_o = cmp_q;
			apb_sys_pkg::HPET_STATUS: rdata_o = apb_sys_pkg::word_t'(status_q);
			default:                  rdata_o = '0;
		endcase
	end

	assign timer_int_o = status_q & ctrl_q[1];

endmodule

// ==== verilog/int_confreg.sv ====
`timescale 1ns/1ps
module int_confreg #(
	parameter int NUM_EXT_INT = 7
) (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic                   sel_i,
	input  apb_sys_pkg::apb_req_t  apb_req_i,
	input  logic                   timer_int_i,
	input  logic [NUM_EXT_INT-1:0] ext_int_i,
	output apb_sys_pkg::word_t     rdata_o,
	output logic                   int_o
);

	logic [NUM_EXT_INT:0] en_q;
	logic [NUM_EXT_INT:0] pend_q; // timer in bit 0
	logic                 int_q;
	logic [3:0]           off;
	logic                 wr;

	assign off = apb_req_i.paddr[3:0];
	assign wr  = sel_i & apb_req_i.penable & apb_req_i.pwrite;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			en_q   <= '0;
			pend_q <= '0;
			int_q  <= 1'b0;
		end else begin
			pend_q <= {ext_int_i, timer_int_i};
			int_q  <= |(pend_q & en_q);
			if (wr && off == apb_sys_pkg::CONF_INT_EN) begin
				en_q <= apb_req_i.pwdata[NUM_EXT_INT:0];
			end
		end
	end

	always_comb begin
		case (off)
			apb_sys_pkg::CONF_INT_EN:   rdata_o = apb_sys_pkg::word_t'(en_q);
			apb_sys_pkg::CONF_INT_PEND: rdata_o = apb_sys_pkg::word_t'(pend_q);
			default:                    rdata_o = '0;
		endcase
	end

	assign int_o = int_q;

endmodule

// ==== verilog/apb_periph_sys.sv ====
`timescale 1ns/1ps
module apb_periph_sys #(
	parameter int RAM_WORDS   = 2048,
	parameter int NUM_EXT_INT = 7
) (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  apb_sys_pkg::apb_req_t  apb_req_i,
	output apb_sys_pkg::apb_rsp_t  apb_rsp_o,
	input  logic [NUM_EXT_INT-1:0] ext_int_i,
	output logic                   int_o
);

	apb_sys_pkg::slot_sel_t sel;
	apb_sys_pkg::word_t     sram_rdata;
	apb_sys_pkg::word_t     hpet_rdata;
	apb_sys_pkg::word_t     conf_rdata;
	logic                   timer_int;

	apb_slot_decode u_apb_slot_decode (
		.apb_req_i    (apb_req_i),
		.sram_rdata_i (sram_rdata),
		.hpet_rdata_i (hpet_rdata),
		.conf_rdata_i (conf_rdata),
		.sel_o        (sel),
		.apb_rsp_o    (apb_rsp_o)
	);

	data_sram #(
		.RAM_WORDS (RAM_WORDS)
	) u_data_sram (
		.clock     (clock),
		.sel_i     (sel[apb_sys_pkg::SLOT_SRAM]),
		.apb_req_i (apb_req_i),
		.rdata_o   (sram_rdata)
	);

	hpet_timer u_hpet_timer (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.sel_i       (sel[apb_sys_pkg::SLOT_HPET]),
		.apb_req_i   (apb_req_i),
		.rdata_o     (hpet_rdata),
		.timer_int_o (timer_int)
	);

	// other peripheral irqs come in as plain levels
	int_confreg #(
		.NUM_EXT_INT (NUM_EXT_INT)
	) u_int_confreg (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.sel_i       (sel[apb_sys_pkg::SLOT_CONF]),
		.apb_req_i   (apb_req_i),
		.timer_int_i (timer_int),
		.ext_int_i   (ext_int_i),
		.rdata_o     (conf_rdata),
		.int_o       (int_o)
	);

endmodule

// ==== verif/apb_periph_sys_asserts.sv ====
`timescale 1ns/1ps
module apb_periph_sys_asserts #(
	parameter int NUM_EXT_INT = 7
) (
	input logic                   clock,
	input logic                   rst_n_i,
	input apb_sys_pkg::apb_req_t  apb_req_i,
	input apb_sys_pkg::apb_rsp_t  apb_rsp_i,
	input logic [NUM_EXT_INT-1:0] ext_int_i,
	input logic                   timer_int_i,
	input logic                   int_i
);

	int fail_cnt = 0; // failures seen so far

	// a transfer ends with its first access cycle
	single_access_cycle: assert property (@(posedge clock) disable iff (!rst_n_i)
		apb_rsp_i.pready |=> !apb_req_i.penable)
	else begin
		fail_cnt++;
		$error("penable still high in the cycle after pready");
	end

	// access cycle follows a setup cycle with psel held
	access_after_setup: assert property (@(posedge clock) disable iff (!rst_n_i)
		apb_req_i.penable |-> apb_req_i.psel && $past(apb_req_i.psel && !apb_req_i.penable))
	else begin
		fail_cnt++;
		$error("penable without a preceding setup cycle");
	end

	// pending is sampled and then registered
	int_quiet_without_source: assert property (@(posedge clock) disable iff (!rst_n_i)
		!$past(|{ext_int_i, timer_int_i}, 2) |-> !int_i)
	else begin
		fail_cnt++;
		$error("int_o high with no source pending two cycles earlier");
	end

endmodule

bind apb_periph_sys apb_periph_sys_asserts #(
	.NUM_EXT_INT (NUM_EXT_INT)
) u_apb_periph_sys_asserts (
	.clock       (clock),
	.rst_n_i     (rst_n_i),
	.apb_req_i   (apb_req_i),
	.apb_rsp_i   (apb_rsp_o),
	.ext_int_i   (ext_int_i),
	.timer_int_i (timer_int),
	.int_i       (int_o)
);

// ==== verif/tb_apb_periph_sys.sv ====
`timescale 1ns/1ps
module tb_apb_periph_sys;

	localparam int RAM_WORDS   = 2048;
	localparam int NUM_EXT_INT = 7;
	localparam int IRQ_W       = NUM_EXT_INT + 1;
	localparam int N_SRAM      = 200;
	localparam int N_IRQ       = 50;
	// cycle budget of each phase, doubled
	localparam int MAX_CYCLES  = 2 * (10 + N_SRAM * 6 + N_IRQ * 14 + 1000);

	logic                   clock = 1'b0;
	logic                   rst_n;
	apb_sys_pkg::apb_req_t  apb_req;
	apb_sys_pkg::apb_rsp_t  apb_rsp;
	logic [NUM_EXT_INT-1:0] ext_int;
	logic                   irq;

	int                 seed = 53;
	int                 cycles = 0;
	apb_sys_pkg::word_t ram_model [128]; // small window so words get rewritten
	bit                 ram_valid [128];
	logic [6:0]         valid_q [$];

	apb_periph_sys #(
		.RAM_WORDS   (RAM_WORDS),
		.NUM_EXT_INT (NUM_EXT_INT)
	) u_apb_periph_sys (
		.clock     (clock),
		.rst_n_i   (rst_n),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp),
		.ext_int_i (ext_int),
		.int_o     (irq)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			stop_run($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input apb_sys_pkg::word_t exp,
			input apb_sys_pkg::word_t act);
		if (act !== exp) begin
			stop_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
		end
	endtask

	function automatic apb_sys_pkg::addr_t slot_addr(input apb_sys_pkg::slot_idx_t s,
			input logic [12:0] off);
		return {s, off};
	endfunction

	function automatic apb_sys_pkg::addr_t sram_addr(input logic [6:0] idx);
		return slot_addr(apb_sys_pkg::SLOT_SRAM, {4'b0, idx, 2'b00});
	endfunction

	function automatic apb_sys_pkg::addr_t hpet_addr(input logic [3:0] off);
		return slot_addr(apb_sys_pkg::SLOT_HPET, {9'b0, off});
	endfunction

	function automatic apb_sys_pkg::addr_t conf_addr(input logic [3:0] off);
		return slot_addr(apb_sys_pkg::SLOT_CONF, {9'b0, off});
	endfunction

	// byte lanes with strobe set take the new data
	function automatic apb_sys_pkg::word_t merge_bytes(input apb_sys_pkg::word_t old,
			input apb_sys_pkg::word_t data, input logic [3:0] strb);
		apb_sys_pkg::word_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic apb_write(input apb_sys_pkg::addr_t addr, input apb_sys_pkg::word_t data,
			input logic [3:0] strb);
		@(posedge clock);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data,
			pstrb: strb};
		@(posedge clock);
		apb_req.penable <= 1'b1;
		@(negedge clock);
		check_bit("write pready", 1'b1, apb_rsp.pready);
		@(posedge clock);
		apb_req <= '0; // back to idle
	endtask

	task automatic apb_read(input apb_sys_pkg::addr_t addr, output apb_sys_pkg::word_t data);
		@(posedge clock);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0,
			pstrb: '0};
		@(posedge clock);
		apb_req.penable <= 1'b1;
		@(negedge clock);
		check_bit("read pready", 1'b1, apb_rsp.pready);
		data = apb_rsp.prdata;
		@(posedge clock);
		apb_req <= '0;
	endtask

	task automatic read_check(input string name, input apb_sys_pkg::addr_t addr,
			input apb_sys_pkg::word_t exp);
		apb_sys_pkg::word_t act;
		apb_read(addr, act);
		check_word(name, exp, act);
	endtask

	initial begin
		apb_sys_pkg::word_t     data;
		apb_sys_pkg::word_t     cmp;
		logic [IRQ_W-1:0]       mask;
		logic [IRQ_W-1:0]       pend;
		logic [NUM_EXT_INT-1:0] ext_val;
		logic [3:0]             strb;
		logic [6:0]             idx;
		logic [6:0]             pick;
		apb_sys_pkg::slot_idx_t unmapped [5];

		rst_n    = 1'b0;
		apb_req  = '0;
		ext_int  = '0;
		unmapped = '{3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;

		@(negedge clock);
		check_bit("reset pready", 1'b0, apb_rsp.pready);
		check_bit("reset int_o", 1'b0, irq);
		read_check("reset hpet ctrl", hpet_addr(apb_sys_pkg::HPET_CTRL), '0);
		read_check("reset hpet count", hpet_addr(apb_sys_pkg::HPET_COUNT), '0);
		read_check("reset hpet cmp", hpet_addr(apb_sys_pkg::HPET_CMP), '0);
		read_check("reset hpet status", hpet_addr(apb_sys_pkg::HPET_STATUS), '0);
		read_check("reset conf int en", conf_addr(apb_sys_pkg::CONF_INT_EN), '0);
		read_check("reset conf int pend", conf_addr(apb_sys_pkg::CONF_INT_PEND), '0);

		for (int n = 0; n < N_SRAM; n++) begin
			idx  = 7'($random(seed));
			data = apb_sys_pkg::word_t'($random(seed));
			strb = ram_valid[idx] ? 4'($random(seed)) : 4'hF; // first write fills the word
			apb_write(sram_addr(idx), data, strb);
			ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
			if (!ram_valid[idx]) begin
				ram_valid[idx] = 1'b1;
				valid_q.push_back(idx);
			end
			pick = valid_q[$unsigned($random(seed)) % valid_q.size()];
			read_check("sram read", sram_addr(pick), ram_model[pick]);
		end

		foreach (unmapped[s]) begin
			read_check("unmapped read", slot_addr(unmapped[s], 13'($random(seed))), '0);
			pick = valid_q[$unsigned($random(seed)) % valid_q.size()];
			apb_write(slot_addr(unmapped[s], {4'b0, pick, 2'b00}),
				apb_sys_pkg::word_t'($random(seed)), 4'hF);
			apb_write(slot_addr(unmapped[s], 13'(apb_sys_pkg::HPET_CMP)), 32'hFFFF_FFFF, 4'hF);
			apb_write(slot_addr(unmapped[s], 13'(apb_sys_pkg::CONF_INT_EN)), 32'hFFFF_FFFF,
				4'hF);
			read_check("unmapped sram alias", sram_addr(pick), ram_model[pick]);
			read_check("unmapped hpet alias", hpet_addr(apb_sys_pkg::HPET_CMP), '0);
			read_check("unmapped conf alias", conf_addr(apb_sys_pkg::CONF_INT_EN), '0);
		end

		cmp  = apb_sys_pkg::word_t'($unsigned($random(seed)) % 50);
		mask = IRQ_W'($random(seed));
		apb_write(conf_addr(apb_sys_pkg::CONF_INT_EN), apb_sys_pkg::word_t'(mask), 4'hF);
		apb_write(hpet_addr(apb_sys_pkg::HPET_COUNT), '0, 4'hF);
		apb_write(hpet_addr(apb_sys_pkg::HPET_CMP), cmp, 4'hF);
		apb_write(hpet_addr(apb_sys_pkg::HPET_CTRL), 32'h3, 4'hF);
		wait_cycles(int'(cmp) + 5);
		read_check("hpet match status", hpet_addr(apb_sys_pkg::HPET_STATUS), 32'h1);
		@(negedge clock);
		check_bit("timer int_o", mask[0], irq);
		apb_write(hpet_addr(apb_sys_pkg::HPET_CTRL), 32'h2, 4'hF); // stop the count and keep int en
		apb_write(hpet_addr(apb_sys_pkg::HPET_STATUS), 32'h1, 4'hF);
		read_check("hpet status clear", hpet_addr(apb_sys_pkg::HPET_STATUS), '0);
		read_check("hpet cmp", hpet_addr(apb_sys_pkg::HPET_CMP), cmp);
		read_check("hpet ctrl", hpet_addr(apb_sys_pkg::HPET_CTRL), 32'h2);
		wait_cycles(2);
		@(negedge clock);
		check_bit("int_o after clear", 1'b0, irq);

		for (int n = 0; n < N_IRQ; n++) begin
			ext_val = NUM_EXT_INT'($random(seed));
			mask    = IRQ_W'($random(seed));
			@(posedge clock);
			ext_int <= ext_val;
			apb_write(conf_addr(apb_sys_pkg::CONF_INT_EN), apb_sys_pkg::word_t'(mask), 4'hF);
			pend = {ext_val, 1'b0}; // timer status is clear by now
			read_check("conf int pend", conf_addr(apb_sys_pkg::CONF_INT_PEND),
				apb_sys_pkg::word_t'(pend));
			read_check("conf int en", conf_addr(apb_sys_pkg::CONF_INT_EN),
				apb_sys_pkg::word_t'(mask));
			wait_cycles(2);
			@(negedge clock);
			check_bit("merged int_o", |(pend & mask), irq);
		end

		if (u_apb_periph_sys.u_apb_periph_sys_asserts.fail_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			stop_run("bound protocol assertions reported failures");
		end
	end

endmodule

// ==== apb_periph_sys.f ====
verilog/apb_sys_pkg.sv
verilog/apb_slot_decode.sv
verilog/data_sram.sv
verilog/hpet_timer.sv
verilog/int_confreg.sv
verilog/apb_periph_sys.sv
verif/apb_periph_sys_asserts.sv
verif/tb_apb_periph_sys.sv

// ==== Makefile ====
SRCS := $(shell cat apb_periph_sys.f)

all: run

obj_dir/Vtb_apb_periph_sys: apb_periph_sys.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_apb_periph_sys -f apb_periph_sys.f

run: obj_dir/Vtb_apb_periph_sys
	-./obj_dir/Vtb_apb_periph_sys +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
